//--- design/soc_pkg.sv
// bus request and response types, address map constants, target and uart state enums
package soc_pkg;

    ////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [7:0]  byte_t;

    // master side of the bus, any strobe set means write
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        data_t  wdata;
        wstrb_t wstrb;
    } bus_req_t;

    // responder side, rdata only meaningful with ready
    typedef struct packed {
        logic  ready;
        data_t rdata;
    } bus_rsp_t;

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////
    typedef enum logic [1:0] {TGT_BRAM, TGT_IO, TGT_NONE} target_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

    ////////////////////////////////////////
    // io address map
    ////////////////////////////////////////
    localparam addr_t UART_DATA_ADDR = 32'h1000_0000;
    localparam addr_t UART_LSR_ADDR  = 32'h1000_0004;
    localparam addr_t CPU_FREQ_ADDR  = 32'h1100_0000;
    localparam addr_t LED_ADDR       = 32'h1200_0000;

    localparam byte_t LED_RESET_VALUE = 8'hF0;

    // line status bit positions
    localparam int LSR_RX_AVAIL_BIT  = 8;
    localparam int LSR_TX_IDLE_BIT_A = 13;
    localparam int LSR_TX_IDLE_BIT_B = 14;

    // uart data read with nothing held
    localparam data_t RX_EMPTY_WORD = 32'hFFFF_FFFF;

endpackage

//--- design/bus_decoder.sv
// address decode, one-cycle target strobes, registered ready and read data mux
`timescale 1ns/10ps

module bus_decoder
    import soc_pkg::*;
#(
    parameter int BRAM_WORDS = 256
) (
    input  logic     clk,
    input  logic     resetn,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    output logic     bram_sel,
    output logic     io_sel,
    input  data_t    bram_rdata,
    input  data_t    io_rdata
);

    localparam addr_t BRAM_LIMIT = addr_t'(BRAM_WORDS * 4);

    target_t tgt;
    target_t tgt_q;
    logic    accept;
    logic    ready_q;
    logic    wr_q;

    ////////////////////////////////////////
    // target decode
    ////////////////////////////////////////
    always_comb begin
        if (req.addr < BRAM_LIMIT) begin
            tgt = TGT_BRAM;
        end else if (req.addr == UART_DATA_ADDR || req.addr == UART_LSR_ADDR ||
                     req.addr == CPU_FREQ_ADDR || req.addr == LED_ADDR) begin
            tgt = TGT_IO;
        end else begin
            tgt = TGT_NONE;
        end
    end

    // valid is ignored while ready is up
    assign accept   = req.valid && !ready_q;
    assign bram_sel = accept && (tgt == TGT_BRAM);
    assign io_sel   = accept && (tgt == TGT_IO);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready_q <= 1'b0;
            tgt_q   <= TGT_NONE;
            wr_q    <= 1'b0;
        end else begin
            ready_q <= accept;
            if (accept) begin
                tgt_q <= tgt;
                wr_q  <= |req.wstrb;
            end
        end
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////
    always_comb begin
        rsp.ready = ready_q;
        rsp.rdata = '0;
        // writes answer with zero data
        if (ready_q && !wr_q) begin
            case (tgt_q)
                TGT_BRAM: rsp.rdata = bram_rdata;
                TGT_IO:   rsp.rdata = io_rdata;
                default:  rsp.rdata = '0;
            endcase
        end
    end

    // one acknowledge per request, never back to back
    a_ready_single: assert property (@(posedge clk) disable iff (!resetn)
        rsp.ready |=> !rsp.ready)
        else $error("bus_decoder: ready high on two consecutive cycles");

endmodule

//--- design/block_ram.sv
// word-organized synchronous ram with byte lane write strobes
`timescale 1ns/10ps

module block_ram
    import soc_pkg::*;
#(
    parameter int BRAM_WORDS = 256
) (
    input  logic   clk,
    input  logic   sel,
    input  addr_t  addr,
    input  data_t  wdata,
    input  wstrb_t wstrb,
    output data_t  rdata
);

    localparam int IDX_W = $clog2(BRAM_WORDS);

    data_t              mem [BRAM_WORDS];
    logic [IDX_W-1:0]   idx;

    // byte address to word index
    assign idx = addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (sel && wstrb[i]) begin
                mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
        // read returns the word before any write this cycle
        rdata <= mem[idx];
    end

endmodule

//--- design/uart_tx.sv
// 8N1 serial transmitter, baud counter and bit state machine
`timescale 1ns/10ps

module uart_tx
    import soc_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  clk,
    input  logic  resetn,
    input  logic  tx_start,
    input  byte_t tx_byte,
    output logic  tx_busy,
    output logic  uart_tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

    uart_tx_state_t   state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;

    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    uart_tx <= 1'b1;
                    cnt     <= '0;
                    if (tx_start) begin
                        shift   <= tx_byte;
                        uart_tx <= 1'b0;
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (cnt == LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        uart_tx <= shift[0];
                        state   <= TX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (cnt == LAST) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            uart_tx <= 1'b1;
                            state   <= TX_STOP;
                        end else begin
                            // lsb first, next bit comes from the shifted value
                            bit_idx <= bit_idx + 1'b1;
                            shift   <= shift >> 1;
                            uart_tx <= shift[1];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == LAST) begin
                        cnt   <= '0;
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!resetn)
        (state == TX_IDLE) |-> uart_tx)
        else $error("uart_tx: line low while idle");

endmodule

//--- design/uart_rx.sv
// 8N1 serial receiver with input synchronizer, mid-bit sampling and one-byte buffer
`timescale 1ns/10ps

module uart_rx
    import soc_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  clk,
    input  logic  resetn,
    input  logic  uart_rx,
    input  logic  rx_pop,
    output logic  rx_valid,
    output byte_t rx_byte
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);

    uart_rx_state_t   state;
    logic [1:0]       sync_q;
    logic             rx_prev;
    logic             rx_s;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;

    ////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sync_q  <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            sync_q  <= {sync_q[0], uart_rx};
            rx_prev <= sync_q[1];
        end
    end

    assign rx_s = sync_q[1];

    ////////////////////////////////////////
    // frame state machine
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_pop) begin
                rx_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    // falling edge starts a frame
                    if (rx_prev && !rx_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt == HALF) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // start bit gone high again, treat as glitch
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == LAST) begin
                        cnt   <= '0;
                        shift <= {rx_s, shift[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == LAST) begin
                        cnt   <= '0;
                        state <= RX_IDLE;
                        // low stop bit drops the frame, new byte overwrites old
                        if (rx_s) begin
                            rx_byte  <= shift;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/io_regs.sv
// uart data and line status, led and clock frequency registers
`timescale 1ns/10ps

module io_regs
    import soc_pkg::*;
#(
    parameter int SYSTEM_CLK_HZ = 25_000_000
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   sel,
    input  addr_t  addr,
    input  data_t  wdata,
    input  wstrb_t wstrb,
    output data_t  rdata,
    output byte_t  led,
    output logic   tx_start,
    output byte_t  tx_byte,
    input  logic   tx_busy,
    output logic   rx_pop,
    input  logic   rx_valid,
    input  byte_t  rx_byte
);

    logic  is_wr;
    logic  hit_data;
    logic  hit_lsr;
    logic  hit_freq;
    logic  hit_led;
    data_t lsr;
    data_t rd_word;

    assign is_wr    = |wstrb;
    assign hit_data = (addr == UART_DATA_ADDR);
    assign hit_lsr  = (addr == UART_LSR_ADDR);
    assign hit_freq = (addr == CPU_FREQ_ADDR);
    assign hit_led  = (addr == LED_ADDR);

    ////////////////////////////////////////
    // uart steering
    ////////////////////////////////////////
    // byte dropped if the transmitter is still busy
    assign tx_start = sel && is_wr && hit_data && !tx_busy;
    assign tx_byte  = wdata[7:0];

    // reading the data register consumes the held byte
    assign rx_pop = sel && !is_wr && hit_data && rx_valid;

    always_comb begin
        lsr                    = '0;
        lsr[LSR_RX_AVAIL_BIT]  = rx_valid;
        lsr[LSR_TX_IDLE_BIT_A] = !tx_busy;
        lsr[LSR_TX_IDLE_BIT_B] = !tx_busy;
    end

    ////////////////////////////////////////
    // read mux and registers
    ////////////////////////////////////////
    always_comb begin
        rd_word = '0;
        if (hit_data) begin
            rd_word = rx_valid ? data_t'(rx_byte) : RX_EMPTY_WORD;
        end else if (hit_lsr) begin
            rd_word = lsr;
        end else if (hit_freq) begin
            rd_word = data_t'(SYSTEM_CLK_HZ);
        end
        // led reads back as zero
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            led <= LED_RESET_VALUE;
        end else if (sel && is_wr && hit_led) begin
            led <= wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= is_wr ? '0 : rd_word;
        end
    end

    // a single access can never both send and pop
    a_tx_rx_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(tx_start && rx_pop))
        else $error("io_regs: tx_start and rx_pop together");

endmodule

//--- design/soc_bus.sv
// peripheral bus top level, decoder, ram, register block and uart
`timescale 1ns/10ps

module soc_bus
    import soc_pkg::*;
#(
    parameter int BRAM_WORDS    = 256,
    parameter int CLKS_PER_BIT  = 8,
    parameter int SYSTEM_CLK_HZ = 25_000_000
) (
    input  logic     clk,
    input  logic     resetn,
    input  bus_req_t req,
    output bus_rsp_t rsp,
    input  logic     uart_rx,
    output logic     uart_tx,
    output byte_t    led
);

    logic  bram_sel;
    logic  io_sel;
    data_t bram_rdata;
    data_t io_rdata;
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_busy;
    logic  rx_pop;
    logic  rx_valid;
    byte_t rx_byte;

    ////////////////////////////////////////
    // bus side
    ////////////////////////////////////////
    bus_decoder #(
        .BRAM_WORDS (BRAM_WORDS)
    ) i_bus_decoder (
        .clk        (clk),
        .resetn     (resetn),
        .req        (req),
        .rsp        (rsp),
        .bram_sel   (bram_sel),
        .io_sel     (io_sel),
        .bram_rdata (bram_rdata),
        .io_rdata   (io_rdata)
    );

    block_ram #(
        .BRAM_WORDS (BRAM_WORDS)
    ) i_block_ram (
        .clk   (clk),
        .sel   (bram_sel),
        .addr  (req.addr),
        .wdata (req.wdata),
        .wstrb (req.wstrb),
        .rdata (bram_rdata)
    );

    io_regs #(
        .SYSTEM_CLK_HZ (SYSTEM_CLK_HZ)
    ) i_io_regs (
        .clk      (clk),
        .resetn   (resetn),
        .sel      (io_sel),
        .addr     (req.addr),
        .wdata    (req.wdata),
        .wstrb    (req.wstrb),
        .rdata    (io_rdata),
        .led      (led),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .rx_pop   (rx_pop),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    ////////////////////////////////////////
    // serial side
    ////////////////////////////////////////
    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk      (clk),
        .resetn   (resetn),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .uart_tx  (uart_tx)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk      (clk),
        .resetn   (resetn),
        .uart_rx  (uart_rx),
        .rx_pop   (rx_pop),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

//--- verification/tb_clock.sv
// testbench clock and synchronous active-low reset generator
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 5
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release on a rising edge, reset is synchronous
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- verification/soc_bus_tb.sv
// dut instance, bus and serial driver tasks, compare tasks, directed tests and summary
`timescale 1ns/10ps

module soc_bus_tb
    import soc_pkg::*;
();

    localparam int BRAM_WORDS    = 256;
    localparam int CLKS_PER_BIT  = 8;
    localparam int SYSTEM_CLK_HZ = 25_000_000;
    localparam int READY_TIMEOUT = 20;
    localparam int EDGE_TIMEOUT  = 40;
    localparam int POLL_LIMIT    = 200;
    localparam int RAM_SLOTS     = 6;

    logic     clk;
    logic     resetn;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     uart_rx;
    logic     uart_tx;
    byte_t    led;
    int       check_count;
    int       mismatch_count;
    int       fail_count;

    tb_clock #(.HALF_PERIOD_NS(2), .RESET_CYCLES(5)) i_tb_clock (.clk(clk), .resetn(resetn));

    soc_bus #(
        .BRAM_WORDS    (BRAM_WORDS),
        .CLKS_PER_BIT  (CLKS_PER_BIT),
        .SYSTEM_CLK_HZ (SYSTEM_CLK_HZ)
    ) i_soc_bus (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .rsp     (rsp),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx),
        .led     (led)
    );

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////
    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // bus master
    ////////////////////////////////////////
    task automatic bus_access(input addr_t address, input data_t wdata, input wstrb_t strb,
                              output data_t rdata);
        int cycles;
        @(posedge clk);
        req.valid <= 1'b1;
        req.addr  <= address;
        req.wdata <= wdata;
        req.wstrb <= strb;
        // still low before the first edge that sees valid
        @(negedge clk);
        check_bit("rsp.ready before accept", rsp.ready, 1'b0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!rsp.ready && cycles < READY_TIMEOUT);
        if (!rsp.ready) begin
            fail_count++;
            $display("no ready from the bus for address 0x%08h within %0d cycles", address, cycles);
        end else if (cycles != 1) begin
            fail_count++;
            $display("ready for address 0x%08h came after %0d cycles, not 1", address, cycles);
        end
        rdata = rsp.rdata;
        @(posedge clk);
        req.valid <= 1'b0;
        // one acknowledge per request
        @(negedge clk);
        check_bit("rsp.ready after acknowledge", rsp.ready, 1'b0);
    endtask

    task automatic bus_write(input addr_t address, input data_t wdata, input wstrb_t strb);
        data_t rdata;
        bus_access(address, wdata, strb, rdata);
        check_data("rsp.rdata on write", rdata, 32'h0);
    endtask

    task automatic bus_read(input addr_t address, output data_t rdata);
        bus_access(address, 32'h0, 4'h0, rdata);
    endtask

    // poll line status until one bit reaches the wanted level
    task automatic wait_line_status(input int bit_pos, input logic level, output data_t lsr);
        int polls;
        polls = 0;
        do begin
            bus_read(UART_LSR_ADDR, lsr);
            polls++;
        end while (lsr[bit_pos] !== level && polls < POLL_LIMIT);
        if (lsr[bit_pos] !== level) begin
            fail_count++;
            $display("line status bit %0d never reached %b in %0d polls", bit_pos, level, polls);
        end
    endtask

    ////////////////////////////////////////
    // serial side
    ////////////////////////////////////////
    task automatic uart_send_frame(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic uart_capture_frame(output byte_t value);
        int    cycles;
        byte_t bits;
        cycles = 0;
        value  = '0;
        do begin
            @(negedge clk);
            cycles++;
        end while (uart_tx && cycles < EDGE_TIMEOUT);
        if (uart_tx) begin
            fail_count++;
            $display("no start bit on uart_tx within %0d cycles", EDGE_TIMEOUT);
        end else begin
            // step to the middle of the start bit
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
            check_bit("uart_tx start bit", uart_tx, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                bits[i] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_bit("uart_tx stop bit", uart_tx, 1'b1);
            value = bits;
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic test_reset();
        int cycles;
        cycles = 0;
        while (resetn !== 1'b1 && cycles < 50) begin
            @(posedge clk);
            cycles++;
        end
        if (resetn !== 1'b1) begin
            fail_count++;
            $display("reset was never released");
        end
        @(negedge clk);
        check_bit("rsp.ready", rsp.ready, 1'b0);
        check_bit("uart_tx", uart_tx, 1'b1);
        check_byte("led", led, 8'hF0);
    endtask

    task automatic test_ram();
        int     span;
        addr_t  addrs [RAM_SLOTS];
        data_t  model [RAM_SLOTS];
        data_t  wdata;
        data_t  rdata;
        wstrb_t strb;
        span = BRAM_WORDS / RAM_SLOTS;
        // one distinct word per slot
        for (int i = 0; i < RAM_SLOTS; i++) begin
            addrs[i] = addr_t'((i * span + int'($urandom % span)) * 4);
            model[i] = $urandom;
            bus_write(addrs[i], model[i], 4'hF);
        end
        for (int i = 0; i < RAM_SLOTS; i++) begin
            bus_read(addrs[i], rdata);
            check_data($sformatf("ram word 0x%0h", addrs[i]), rdata, model[i]);
        end
        for (int i = 0; i < RAM_SLOTS; i++) begin
            wdata = $urandom;
            strb  = wstrb_t'($urandom % 15 + 1);
            bus_write(addrs[i], wdata, strb);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[i][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            bus_read(addrs[i], rdata);
            check_data($sformatf("ram word 0x%0h strb %b", addrs[i], strb), rdata, model[i]);
        end
    endtask

    task automatic test_led_and_freq();
        data_t rdata;
        bus_write(LED_ADDR, 32'h1234_565A, 4'hF);
        @(negedge clk);
        check_byte("led", led, 8'h5A);
        bus_read(LED_ADDR, rdata);
        check_data("led readback", rdata, 32'h0);
        bus_read(CPU_FREQ_ADDR, rdata);
        check_data("cpu frequency", rdata, 32'd25_000_000);
        bus_read(32'h2000_0000, rdata);
        check_data("unmapped read", rdata, 32'h0);
    endtask

    task automatic test_uart_tx();
        data_t lsr;
        data_t busy_lsr;
        byte_t got;
        wait_line_status(LSR_TX_IDLE_BIT_A, 1'b1, lsr);
        check_bit("lsr tx idle b before send", lsr[LSR_TX_IDLE_BIT_B], 1'b1);
        fork
            uart_capture_frame(got);
            begin
                bus_write(UART_DATA_ADDR, 32'h0000_00A7, 4'h1);
                bus_read(UART_LSR_ADDR, busy_lsr);
                check_bit("lsr tx idle a while sending", busy_lsr[LSR_TX_IDLE_BIT_A], 1'b0);
                check_bit("lsr tx idle b while sending", busy_lsr[LSR_TX_IDLE_BIT_B], 1'b0);
            end
        join
        check_byte("uart_tx frame", got, 8'hA7);
        wait_line_status(LSR_TX_IDLE_BIT_A, 1'b1, lsr);
        check_bit("lsr tx idle b after send", lsr[LSR_TX_IDLE_BIT_B], 1'b1);
    endtask

    task automatic test_uart_rx();
        data_t lsr;
        data_t rdata;
        uart_send_frame(8'h3C);
        wait_line_status(LSR_RX_AVAIL_BIT, 1'b1, lsr);
        bus_read(UART_DATA_ADDR, rdata);
        check_data("uart data", rdata, 32'h0000_003C);
        // buffer is empty after the pop
        bus_read(UART_DATA_ADDR, rdata);
        check_data("uart data when empty", rdata, 32'hFFFF_FFFF);
        bus_read(UART_LSR_ADDR, lsr);
        check_bit("lsr rx available", lsr[LSR_RX_AVAIL_BIT], 1'b0);
    endtask

    initial begin
        req            <= '0;
        uart_rx        <= 1'b1;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        void'($urandom(3509));
        test_reset();
        test_ram();
        test_led_and_freq();
        test_uart_tx();
        test_uart_rx();
        repeat (2) @(posedge clk);
        $display("checks: %0d  mismatches: %0d  other failures: %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- soc_bus.f
design/soc_pkg.sv
design/bus_decoder.sv
design/block_ram.sv
design/uart_tx.sv
design/uart_rx.sv
design/io_regs.sv
design/soc_bus.sv
verification/tb_clock.sv
verification/soc_bus_tb.sv

//--- Makefile
TOP = soc_bus_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f soc_bus.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
